// ==== rtl/dram_app_pkg.sv ====
// memory application port definitions
// line widths, command encoding and byte mask constants of the DDR IP core side

package dram_app_pkg;

    // line address and data widths of the application port
    localparam int APP_ADDR_W = 27;
    localparam int APP_DATA_W = 128;
    localparam int APP_MASK_W = APP_DATA_W / 8;

    // mask bit at 1 keeps the byte, so all ones writes nothing
    localparam logic [APP_MASK_W-1:0] APP_MASK_ALL = {APP_MASK_W{1'b1}};

    // command field encoding of the IP core
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } app_cmd_e;

endpackage

// ==== rtl/dram_user_pkg.sv ====
// user side definitions of the DRAM front end
// word widths, lane layout inside a memory line and stage state encodings

package dram_user_pkg;

    // 32-bit requester
    localparam int USER_ADDR_W = 32;
    localparam int USER_DATA_W = 32;
    localparam int USER_MASK_W = USER_DATA_W / 8;

    // words per line and where lane and line fields sit in the byte address
    localparam int LANES    = 4;
    localparam int LANE_W   = $clog2(LANES);
    localparam int LANE_LSB = 2;
    localparam int LINE_LSB = LANE_LSB + LANE_W;

    // return stage
    typedef enum logic [1:0] {
        RET_IDLE,
        RET_WAIT,
        RET_ACK
    } ret_state_e;

    // issue stage, command and write data tracked separately
    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_CMD_DATA,
        ISS_CMD,
        ISS_DATA
    } issue_state_e;

endpackage

// ==== rtl/dram_req_decode.sv ====
// request decode stage of the DRAM front end
// synchronizes the calibration flag and captures one user word
// into a line address, replicated line data and a per-byte mask
`timescale 1ns/1ps

module dram_req_decode (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    input  logic                                  i_init_calib_complete,
    input  logic                                  i_req,
    input  logic                                  i_we,
    input  logic [dram_user_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [dram_user_pkg::USER_DATA_W-1:0] i_wdata,
    input  logic [dram_user_pkg::USER_MASK_W-1:0] i_mask,
    input  logic                                  i_ret_idle,
    output logic                                  o_calib_done,
    output logic                                  o_start,
    output logic                                  o_is_write,
    output logic [dram_user_pkg::LANE_W-1:0]      o_lane,
    output logic [dram_app_pkg::APP_ADDR_W-1:0]   o_line_addr,
    output logic [dram_app_pkg::APP_DATA_W-1:0]   o_line_data,
    output logic [dram_app_pkg::APP_MASK_W-1:0]   o_line_mask,
    output dram_app_pkg::app_cmd_e                o_cmd
);
    import dram_app_pkg::*;
    import dram_user_pkg::*;

    logic                  calib_sync1;
    logic                  calib_sync2;
    logic                  accept;
    logic [LANE_W-1:0]     lane_d;
    logic [APP_MASK_W-1:0] line_mask_d;

    // two-flop synchronizer on the calibration flag
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync1 <= 1'b0;
            calib_sync2 <= 1'b0;
        end else begin
            calib_sync1 <= i_init_calib_complete;
            calib_sync2 <= calib_sync1;
        end
    end

    assign o_calib_done = calib_sync2;

    // o_start blocks the edge where return has not left idle yet
    assign accept = i_req && i_ret_idle && calib_sync2 && !o_start;
    assign lane_d = i_addr[LANE_LSB +: LANE_W];

    // only the addressed lane may be written
    always_comb begin
        line_mask_d = APP_MASK_ALL;
        if (i_we) begin
            line_mask_d[lane_d*USER_MASK_W +: USER_MASK_W] = i_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            o_start <= 1'b0;
        end else begin
            o_start <= accept;
        end
    end

    // request fields, held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            o_is_write  <= i_we;
            o_lane      <= lane_d;
            o_line_addr <= i_addr[LINE_LSB +: APP_ADDR_W];
            o_line_data <= {LANES{i_wdata}};
            o_line_mask <= line_mask_d;
            if (i_we) begin
                o_cmd <= CMD_WRITE;
            end else begin
                o_cmd <= CMD_READ;
            end
        end
    end

    // one request in flight, so return must be idle whenever a new one starts
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_x_async)
        o_start |-> i_ret_idle
    );

endmodule

// ==== rtl/dram_cmd_issue.sv ====
// command and write data issue stage of the DRAM front end
// raises app_en and app_wdf_wren after start and holds each one
// until the memory accepts it, in either order
`timescale 1ns/1ps

module dram_cmd_issue (
    input  logic                                clk,
    input  logic                                rst_x_async,
    input  logic                                i_start,
    input  logic                                i_is_write,
    input  logic [dram_app_pkg::APP_ADDR_W-1:0] i_line_addr,
    input  logic [dram_app_pkg::APP_DATA_W-1:0] i_line_data,
    input  logic [dram_app_pkg::APP_MASK_W-1:0] i_line_mask,
    input  dram_app_pkg::app_cmd_e              i_cmd,
    input  logic                                i_app_rdy,
    input  logic                                i_app_wdf_rdy,
    output logic                                o_app_en,
    output dram_app_pkg::app_cmd_e              o_app_cmd,
    output logic [dram_app_pkg::APP_ADDR_W-1:0] o_app_addr,
    output logic                                o_app_wdf_wren,
    output logic [dram_app_pkg::APP_DATA_W-1:0] o_app_wdf_data,
    output logic [dram_app_pkg::APP_MASK_W-1:0] o_app_wdf_mask,
    output logic                                o_wr_done
);
    import dram_app_pkg::*;
    import dram_user_pkg::*;

    issue_state_e state;

    // decode holds its fields until the next request, which cannot
    // be accepted before this one has completed
    assign o_app_cmd      = i_cmd;
    assign o_app_addr     = i_line_addr;
    assign o_app_wdf_data = i_line_data;
    assign o_app_wdf_mask = i_line_mask;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state          <= ISS_IDLE;
            o_app_en       <= 1'b0;
            o_app_wdf_wren <= 1'b0;
        end else begin
            case (state)
                ISS_IDLE: begin
                    if (i_start) begin
                        o_app_en <= 1'b1;
                        if (i_is_write) begin
                            o_app_wdf_wren <= 1'b1;
                            state          <= ISS_CMD_DATA;
                        end else begin
                            state <= ISS_CMD;
                        end
                    end
                end
                ISS_CMD_DATA: begin
                    if (i_app_rdy && i_app_wdf_rdy) begin
                        o_app_en       <= 1'b0;
                        o_app_wdf_wren <= 1'b0;
                        state          <= ISS_IDLE;
                    end else if (i_app_rdy) begin
                        // command taken, data still pending
                        o_app_en <= 1'b0;
                        state    <= ISS_DATA;
                    end else if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= ISS_CMD;
                    end
                end
                ISS_CMD: begin
                    if (i_app_rdy) begin
                        o_app_en <= 1'b0;
                        state    <= ISS_IDLE;
                    end
                end
                ISS_DATA: begin
                    if (i_app_wdf_rdy) begin
                        o_app_wdf_wren <= 1'b0;
                        state          <= ISS_IDLE;
                    end
                end
                default: begin
                    o_app_en       <= 1'b0;
                    o_app_wdf_wren <= 1'b0;
                    state          <= ISS_IDLE;
                end
            endcase
        end
    end

    // write complete on the edge that takes the later of the two halves
    assign o_wr_done = i_is_write &&
        (((state == ISS_CMD_DATA) && i_app_rdy && i_app_wdf_rdy) ||
         ((state == ISS_CMD) && i_app_rdy) ||
         ((state == ISS_DATA) && i_app_wdf_rdy));

    // stalled command keeps its fields
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (!rst_x_async)
        (o_app_en && !i_app_rdy) |=>
            (o_app_en && $stable(o_app_cmd) && $stable(o_app_addr))
    );

    a_no_wdata_on_read: assert property (
        @(posedge clk) disable iff (!rst_x_async)
        o_app_wdf_wren |-> (o_app_cmd == CMD_WRITE)
    );

endmodule

// ==== rtl/dram_read_return.sv ====
// return stage of the DRAM front end
// follows the request to completion, picks the word lane out of
// the returned line and runs the ack side of the user handshake
`timescale 1ns/1ps

module dram_read_return (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    input  logic                                  i_start,
    input  logic                                  i_is_write,
    input  logic [dram_user_pkg::LANE_W-1:0]      i_lane,
    input  logic                                  i_wr_done,
    input  logic [dram_app_pkg::APP_DATA_W-1:0]   i_app_rd_data,
    input  logic                                  i_app_rd_data_valid,
    input  logic                                  i_req,
    output logic                                  o_ret_idle,
    output logic                                  o_ack,
    output logic [dram_user_pkg::USER_DATA_W-1:0] o_rdata
);
    import dram_user_pkg::*;

    ret_state_e        state;
    logic              wr_q;
    logic [LANE_W-1:0] lane_q;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= RET_IDLE;
        end else begin
            case (state)
                RET_IDLE: begin
                    if (i_start) begin
                        state <= RET_WAIT;
                    end
                end
                RET_WAIT: begin
                    if (wr_q ? i_wr_done : i_app_rd_data_valid) begin
                        state <= RET_ACK;
                    end
                end
                RET_ACK: begin
                    // four-phase, wait for the requester to let go
                    if (!i_req) begin
                        state <= RET_IDLE;
                    end
                end
                default: begin
                    state <= RET_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RET_IDLE && i_start) begin
            wr_q   <= i_is_write;
            lane_q <= i_lane;
        end
        if (state == RET_WAIT && !wr_q && i_app_rd_data_valid) begin
            o_rdata <= i_app_rd_data[lane_q*USER_DATA_W +: USER_DATA_W];
        end
    end

    assign o_ret_idle = (state == RET_IDLE);
    assign o_ack      = (state == RET_ACK);

    // memory must not return data nobody asked for
    a_no_stray_rdata: assert property (
        @(posedge clk) disable iff (!rst_x_async)
        i_app_rd_data_valid |-> (state != RET_IDLE)
    );

endmodule

// ==== rtl/dram_frontend.sv ====
// DRAM front end top level
// connects a 32-bit four-phase requester to a 128-bit memory
// application port through decode, issue and return stages
`timescale 1ns/1ps

module dram_frontend (
    input  logic                                  clk,
    input  logic                                  rst_x_async,
    // user side
    input  logic                                  i_req,
    input  logic                                  i_we,
    input  logic [dram_user_pkg::USER_ADDR_W-1:0] i_addr,
    input  logic [dram_user_pkg::USER_DATA_W-1:0] i_wdata,
    input  logic [dram_user_pkg::USER_MASK_W-1:0] i_mask,
    output logic                                  o_ack,
    output logic [dram_user_pkg::USER_DATA_W-1:0] o_rdata,
    output logic                                  o_calib_done,
    // memory side
    output logic                                  o_app_en,
    output dram_app_pkg::app_cmd_e                o_app_cmd,
    output logic [dram_app_pkg::APP_ADDR_W-1:0]   o_app_addr,
    output logic                                  o_app_wdf_wren,
    output logic [dram_app_pkg::APP_DATA_W-1:0]   o_app_wdf_data,
    output logic [dram_app_pkg::APP_MASK_W-1:0]   o_app_wdf_mask,
    input  logic                                  i_app_rdy,
    input  logic                                  i_app_wdf_rdy,
    input  logic [dram_app_pkg::APP_DATA_W-1:0]   i_app_rd_data,
    input  logic                                  i_app_rd_data_valid,
    input  logic                                  i_init_calib_complete
);
    import dram_app_pkg::*;
    import dram_user_pkg::*;

    logic                  start;
    logic                  is_write;
    logic [LANE_W-1:0]     lane;
    logic [APP_ADDR_W-1:0] line_addr;
    logic [APP_DATA_W-1:0] line_data;
    logic [APP_MASK_W-1:0] line_mask;
    app_cmd_e              cmd;
    logic                  wr_done;
    logic                  ret_idle;

    dram_req_decode u_decode (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_req                 (i_req),
        .i_we                  (i_we),
        .i_addr                (i_addr),
        .i_wdata               (i_wdata),
        .i_mask                (i_mask),
        .i_ret_idle            (ret_idle),
        .o_calib_done          (o_calib_done),
        .o_start               (start),
        .o_is_write            (is_write),
        .o_lane                (lane),
        .o_line_addr           (line_addr),
        .o_line_data           (line_data),
        .o_line_mask           (line_mask),
        .o_cmd                 (cmd)
    );

    dram_cmd_issue u_issue (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_start        (start),
        .i_is_write     (is_write),
        .i_line_addr    (line_addr),
        .i_line_data    (line_data),
        .i_line_mask    (line_mask),
        .i_cmd          (cmd),
        .i_app_rdy      (i_app_rdy),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .o_app_en       (o_app_en),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_mask (o_app_wdf_mask),
        .o_wr_done      (wr_done)
    );

    dram_read_return u_return (
        .clk                 (clk),
        .rst_x_async         (rst_x_async),
        .i_start             (start),
        .i_is_write          (is_write),
        .i_lane              (lane),
        .i_wr_done           (wr_done),
        .i_app_rd_data       (i_app_rd_data),
        .i_app_rd_data_valid (i_app_rd_data_valid),
        .i_req               (i_req),
        .o_ret_idle          (ret_idle),
        .o_ack               (o_ack),
        .o_rdata             (o_rdata)
    );

endmodule

// ==== verification/app_mem_model.sv ====
// behavioral model of the memory application port
// 64-line store with byte masks, random ready stalls and a fixed read latency
`timescale 1ns/1ps

module app_mem_model (
    input  logic                                clk,
    input  logic                                rst_x_async,
    input  logic                                i_app_en,
    input  dram_app_pkg::app_cmd_e              i_app_cmd,
    input  logic [dram_app_pkg::APP_ADDR_W-1:0] i_app_addr,
    input  logic                                i_app_wdf_wren,
    input  logic [dram_app_pkg::APP_DATA_W-1:0] i_app_wdf_data,
    input  logic [dram_app_pkg::APP_MASK_W-1:0] i_app_wdf_mask,
    output logic                                o_app_rdy,
    output logic                                o_app_wdf_rdy,
    output logic [dram_app_pkg::APP_DATA_W-1:0] o_app_rd_data,
    output logic                                o_app_rd_data_valid,
    output logic                                o_init_calib_complete
);
    import dram_app_pkg::*;

    logic [APP_DATA_W-1:0] mem [64];
    integer                seed;
    logic [4:0]            calib_cnt;
    logic                  cmd_seen;
    logic                  data_seen;
    logic [5:0]            wr_line;
    logic [APP_DATA_W-1:0] wr_data;
    logic [APP_MASK_W-1:0] wr_mask;
    logic [5:0]            rd_line;
    logic [2:0]            rd_pipe;
    logic                  wr_cmd_acc;
    logic                  wr_dat_acc;
    logic                  rd_acc;

    initial begin
        seed          = 32'h7cce;
        o_app_rdy     = 1'b0;
        o_app_wdf_rdy = 1'b0;
    end

    // each ready is low about one cycle in four
    always @(negedge clk) begin : stall
        logic [31:0] rnd;
        rnd           = $random(seed);
        o_app_rdy     = (rnd[1:0] != 2'd0);
        o_app_wdf_rdy = (rnd[3:2] != 2'd0);
    end

    assign wr_cmd_acc          = i_app_en && o_app_rdy && (i_app_cmd == CMD_WRITE);
    assign rd_acc              = i_app_en && o_app_rdy && (i_app_cmd == CMD_READ);
    assign wr_dat_acc          = i_app_wdf_wren && o_app_wdf_rdy;
    assign o_app_rd_data_valid = rd_pipe[2];
    assign o_app_rd_data       = mem[rd_line];

    always @(posedge clk or negedge rst_x_async) begin : store
        logic [APP_DATA_W-1:0] nl;
        logic [5:0]            line_idx;
        logic [APP_DATA_W-1:0] din;
        logic [APP_MASK_W-1:0] mask;
        if (!rst_x_async) begin
            cmd_seen  <= 1'b0;
            data_seen <= 1'b0;
            rd_pipe   <= 3'd0;
            // every word holds its own word index
            for (int l = 0; l < 64; l++) begin
                for (int w = 0; w < 4; w++) begin
                    nl[w*32 +: 32] = 32'hd00d_0000 | {24'd0, l[5:0], w[1:0]};
                end
                mem[l[5:0]] <= nl;
            end
        end else begin
            rd_pipe <= {rd_pipe[1:0], rd_acc};
            if (rd_acc) begin
                rd_line <= i_app_addr[5:0];
            end
            line_idx = wr_cmd_acc ? i_app_addr[5:0] : wr_line;
            din      = wr_dat_acc ? i_app_wdf_data : wr_data;
            mask     = wr_dat_acc ? i_app_wdf_mask : wr_mask;
            // write once both halves are in, whichever came first
            if ((cmd_seen || wr_cmd_acc) && (data_seen || wr_dat_acc)) begin
                nl = mem[line_idx];
                for (int b = 0; b < APP_MASK_W; b++) begin
                    if (!mask[b]) begin
                        nl[b*8 +: 8] = din[b*8 +: 8];
                    end
                end
                mem[line_idx] <= nl;
                cmd_seen      <= 1'b0;
                data_seen     <= 1'b0;
            end else begin
                if (wr_cmd_acc) begin
                    cmd_seen <= 1'b1;
                    wr_line  <= i_app_addr[5:0];
                end
                if (wr_dat_acc) begin
                    data_seen <= 1'b1;
                    wr_data   <= i_app_wdf_data;
                    wr_mask   <= i_app_wdf_mask;
                end
            end
        end
    end

    always @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_cnt             <= 5'd0;
            o_init_calib_complete <= 1'b0;
        end else if (calib_cnt != 5'd20) begin
            calib_cnt <= calib_cnt + 5'd1;
        end else begin
            o_init_calib_complete <= 1'b1;
        end
    end

endmodule

// ==== verification/tb_dram_frontend.sv ====
// testbench for the DRAM front end
// directed and random requests against a behavioral memory model
`timescale 1ns/1ps

module tb_dram_frontend;
    import dram_app_pkg::*;

    localparam int NUM_RAND = 40;
    localparam int NUM_REQ  = 14 + NUM_RAND;

    logic                  clk;
    logic                  rst_x_async;
    logic                  i_req;
    logic                  i_we;
    logic [31:0]           i_addr;
    logic [31:0]           i_wdata;
    logic [3:0]            i_mask;
    logic                  o_ack;
    logic [31:0]           o_rdata;
    logic                  o_calib_done;
    logic                  o_app_en;
    app_cmd_e              o_app_cmd;
    logic [APP_ADDR_W-1:0] o_app_addr;
    logic                  o_app_wdf_wren;
    logic [APP_DATA_W-1:0] o_app_wdf_data;
    logic [APP_MASK_W-1:0] o_app_wdf_mask;
    logic                  i_app_rdy;
    logic                  i_app_wdf_rdy;
    logic [APP_DATA_W-1:0] i_app_rd_data;
    logic                  i_app_rd_data_valid;
    logic                  i_init_calib_complete;
    logic [31:0]           shadow [256];
    logic [31:0]           last_rdata;
    logic [31:0]           rnd;
    integer                seed;

    dram_frontend dut (.*);

    app_mem_model u_mem (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_app_en              (o_app_en),
        .i_app_cmd             (o_app_cmd),
        .i_app_addr            (o_app_addr),
        .i_app_wdf_wren        (o_app_wdf_wren),
        .i_app_wdf_data        (o_app_wdf_data),
        .i_app_wdf_mask        (o_app_wdf_mask),
        .o_app_rdy             (i_app_rdy),
        .o_app_wdf_rdy         (i_app_wdf_rdy),
        .o_app_rd_data         (i_app_rd_data),
        .o_app_rd_data_valid   (i_app_rd_data_valid),
        .o_init_calib_complete (i_init_calib_complete)
    );

    task automatic fail_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "data mismatch");
    endtask

    task automatic fail_protocol(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "protocol violation");
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return 32'hd00d_0000 | {24'd0, idx};
    endfunction

    // mask bit at 1 keeps the old byte
    function automatic logic [31:0] merge_word(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] mask);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (!mask[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // one four-phase transfer on word index idx
    task automatic transfer(input logic we, input logic [7:0] idx,
                            input logic [31:0] data, input logic [3:0] mask);
        @(negedge clk);
        i_req   = 1'b1;
        i_we    = we;
        i_addr  = {22'd0, idx, 2'b00};
        i_wdata = data;
        i_mask  = mask;
        @(negedge clk);
        while (!o_ack) @(negedge clk);
        last_rdata = o_rdata;
        i_req      = 1'b0;
        while (o_ack) @(negedge clk);
        if (we) begin
            shadow[idx] = merge_word(shadow[idx], data, mask);
        end
    endtask

    task automatic write_word(input logic [7:0] idx, input logic [31:0] data,
                              input logic [3:0] mask);
        transfer(1'b1, idx, data, mask);
    endtask

    task automatic read_check(input string name, input logic [7:0] idx);
        transfer(1'b0, idx, 32'd0, 4'hf);
        assert (last_rdata == shadow[idx]) else fail_value(name, shadow[idx], last_rdata);
    endtask

    // calibration flag crosses two flops before it reaches the user side
    a_calib_done_delay: assert property (@(posedge clk) disable iff (!rst_x_async)
        o_calib_done == $past(i_init_calib_complete, 2))
        else fail_protocol("calib_done did not follow the memory calibration flag by two cycles");

    a_ack_after_calib: assert property (@(posedge clk) disable iff (!rst_x_async)
        (o_ack || o_app_en) |-> o_calib_done)
        else fail_protocol("request served before calibration completed");

    // covers both ack rising without req and ack coming back before the next req
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_x_async)
        (!i_req && !o_ack) |=> !o_ack)
        else fail_protocol("ack rose while no request was pending");

    a_ack_release: assert property (@(posedge clk) disable iff (!rst_x_async)
        (o_ack && !i_req) |=> !o_ack)
        else fail_protocol("ack still high one cycle after req fell");

    a_en_held: assert property (@(posedge clk) disable iff (!rst_x_async)
        (o_app_en && !i_app_rdy) |=> o_app_en)
        else fail_protocol("app_en dropped before the command was accepted");

    a_wren_held: assert property (@(posedge clk) disable iff (!rst_x_async)
        (o_app_wdf_wren && !i_app_wdf_rdy) |=>
            (o_app_wdf_wren && $stable(o_app_wdf_data) && $stable(o_app_wdf_mask)))
        else fail_protocol("write data strobe changed before it was accepted");

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        repeat (NUM_REQ * 40 + 100) @(posedge clk);
        $display("timeout: requests did not complete in time");
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed        = 32'h7cce;
        rst_x_async = 1'b0;
        i_req       = 1'b0;
        i_we        = 1'b0;
        i_addr      = 32'd0;
        i_wdata     = 32'd0;
        i_mask      = 4'h0;
        for (int w = 0; w < 256; w++) begin
            shadow[w[7:0]] = fill_word(w[7:0]);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_x_async = 1'b1;

        // request raised while calibration is still running
        assert (!o_calib_done) else fail_protocol("calibration done before the gating request");
        write_word(8'd1, 32'hcafe_0001, 4'h0);

        write_word(8'd5, 32'h1234_5678, 4'h0);
        read_check("write_read", 8'd5);

        write_word(8'd9, 32'h1122_3344, 4'h0);
        write_word(8'd9, 32'haabb_ccdd, 4'b0101);
        read_check("byte_mask", 8'd9);

        for (int l = 0; l < 4; l++) begin
            write_word({6'd12, l[1:0]}, {16'h0f0f, 14'd0, l[1:0]}, 4'h0);
        end
        for (int l = 0; l < 4; l++) begin
            read_check("lane_independence", {6'd12, l[1:0]});
        end

        // random mix on a small window so reads hit earlier writes
        for (int i = 0; i < NUM_RAND; i++) begin
            rnd = $random(seed);
            if (rnd[0]) begin
                write_word({3'b010, rnd[12:8]}, $random(seed), rnd[7:4]);
            end else begin
                read_check("back_pressure", {3'b010, rnd[12:8]});
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
rtl/dram_app_pkg.sv
rtl/dram_user_pkg.sv
rtl/dram_req_decode.sv
rtl/dram_cmd_issue.sv
rtl/dram_read_return.sv
rtl/dram_frontend.sv
verification/app_mem_model.sv
verification/tb_dram_frontend.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_dram_frontend -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir
